//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module execCoreTb -o simExecCore
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simExecCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- src/aluStage.sv
module aluStage
    import rvExecPkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  decodedOp_t  decoded,
    input  logic [31:0] readData1,
    input  logic [31:0] readData2,
    output execResult_t result,
    output logic        resultValid
);

    logic        heldWrites;
    logic        fwdA;
    logic        fwdB;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluOut;

    // previous instruction has not reached the register file yet
    assign heldWrites = resultValid && result.writeEn && (result.rd != 5'd0);
    assign fwdA = heldWrites && (result.rd == decoded.rs1);
    assign fwdB = heldWrites && (result.rd == decoded.rs2);

    assign srcA = fwdA ? result.value : readData1;
    assign srcB = fwdB ? result.value : readData2;

    assign opA = decoded.zeroA ? 32'd0 : srcA;
    assign opB = decoded.useImm ? decoded.imm : srcB;

    intAlu i_alu (
        .opA    (opA),
        .opB    (opB),
        .aluOp  (decoded.aluOp),
        .result (aluOut)
    );

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= decoded.valid;
            if (decoded.valid) begin
                result.rd      <= decoded.rd;
                result.value   <= decoded.illegal ? 32'd0 : aluOut;
                result.writeEn <= decoded.writeEn;
                result.illegal <= decoded.illegal;
            end
        end
    end

endmodule

//--- src/execCore.sv
module execCore
    import rvExecPkg::*;
#(
    parameter int numRegs = 32   // 16 for rv32e
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] instr,
    input  logic        instrValid,
    output execResult_t result,
    output logic        resultValid
);

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] readData1;
    logic [31:0] readData2;
    decodedOp_t  decoded;

    instrDecoder #(
        .numRegs (numRegs)
    ) i_decoder (
        .CLK        (CLK),
        .RESET      (RESET),
        .instr      (instr),
        .instrValid (instrValid),
        .rs1        (rs1),
        .rs2        (rs2),
        .decoded    (decoded)
    );

    // write port fed back from the result register
    regFile #(
        .numRegs (numRegs)
    ) i_regFile (
        .CLK       (CLK),
        .RESET     (RESET),
        .readReg1  (rs1),
        .readReg2  (rs2),
        .writeReg  (result.rd),
        .writeData (result.value),
        .regWrite  (resultValid & result.writeEn),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    aluStage i_aluStage (
        .CLK         (CLK),
        .RESET       (RESET),
        .decoded     (decoded),
        .readData1   (readData1),
        .readData2   (readData2),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

//--- src/instrDecoder.sv
module instrDecoder
    import rvExecPkg::*;
#(
    parameter int numRegs = 32
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] instr,
    input  logic        instrValid,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output decodedOp_t  decoded
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    logic       usesRs1;
    logic       usesRs2;
    decodedOp_t decodedNext;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register file reads the raw fields every cycle
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    always_comb begin
        decodedNext       = '0;
        decodedNext.aluOp = aluAdd;
        decodedNext.rd    = instr[11:7];
        decodedNext.rs1   = instr[19:15];
        decodedNext.rs2   = instr[24:20];
        legal   = 1'b1;
        usesRs1 = 1'b0;
        usesRs2 = 1'b0;

        case (opcode)
            opOp: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                case (funct3)
                    3'd0: decodedNext.aluOp = funct7[5] ? aluSub : aluAdd;
                    3'd1: decodedNext.aluOp = aluSll;
                    3'd2: decodedNext.aluOp = aluSlt;
                    3'd3: decodedNext.aluOp = aluSltu;
                    3'd4: decodedNext.aluOp = aluXor;
                    3'd5: decodedNext.aluOp = funct7[5] ? aluSra : aluSrl;
                    3'd6: decodedNext.aluOp = aluOr;
                    default: decodedNext.aluOp = aluAnd;
                endcase
                // 0x20 only allowed on sub and sra
                if (funct7 == 7'h20) begin
                    legal = (funct3 == 3'd0) || (funct3 == 3'd5);
                end else begin
                    legal = (funct7 == 7'h00);
                end
            end
            opOpImm: begin
                usesRs1 = 1'b1;
                decodedNext.rs2    = 5'd0;   // field belongs to the immediate
                decodedNext.useImm = 1'b1;
                decodedNext.imm    = {{20{instr[31]}}, instr[31:20]};
                case (funct3)
                    3'd0: decodedNext.aluOp = aluAdd;
                    3'd1: decodedNext.aluOp = aluSll;
                    3'd2: decodedNext.aluOp = aluSlt;
                    3'd3: decodedNext.aluOp = aluSltu;
                    3'd4: decodedNext.aluOp = aluXor;
                    3'd5: decodedNext.aluOp = funct7[5] ? aluSra : aluSrl;
                    3'd6: decodedNext.aluOp = aluOr;
                    default: decodedNext.aluOp = aluAnd;
                endcase
                if (funct3 == 3'd1) begin
                    legal = (funct7 == 7'h00);
                end else if (funct3 == 3'd5) begin
                    legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                end
            end
            opLui: begin
                decodedNext.rs1    = 5'd0;
                decodedNext.rs2    = 5'd0;
                decodedNext.aluOp  = aluPassB;
                decodedNext.useImm = 1'b1;
                decodedNext.zeroA  = 1'b1;
                decodedNext.imm    = {instr[31:12], 12'd0};
            end
            default: legal = 1'b0;
        endcase

        // registers beyond the implemented set (rv32e)
        if (int'(decodedNext.rd) >= numRegs) legal = 1'b0;
        if (usesRs1 && int'(decodedNext.rs1) >= numRegs) legal = 1'b0;
        if (usesRs2 && int'(decodedNext.rs2) >= numRegs) legal = 1'b0;

        decodedNext.writeEn = legal;
        decodedNext.illegal = !legal;
        decodedNext.valid   = 1'b1;

        if (!instrValid) begin
            decodedNext = '0;   // bubble
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            decoded <= '0;
        end else begin
            decoded <= decodedNext;
        end
    end

endmodule

//--- src/intAlu.sv
module intAlu
    import rvExecPkg::*;
(
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  aluOp_e      aluOp,
    output logic [31:0] result
);

    logic [4:0] shamt;

    assign shamt = opB[4:0];   // only five bits count

    always_comb begin
        case (aluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluSll:   result = opA << shamt;
            aluSlt:   result = {31'd0, $signed(opA) < $signed(opB)};
            aluSltu:  result = {31'd0, opA < opB};
            aluXor:   result = opA ^ opB;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = $unsigned($signed(opA) >>> shamt);
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluPassB: result = opB;
            default:  result = 32'd0;
        endcase
    end

endmodule

//--- src/regFile.sv
module regFile #(
    parameter int numRegs = 32
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [4:0]  readReg1,
    input  logic [4:0]  readReg2,
    input  logic [4:0]  writeReg,
    input  logic [31:0] writeData,
    input  logic        regWrite,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    localparam int idxW = $clog2(numRegs);

    logic [31:0] regs [numRegs];

    logic        writeHit;
    logic [31:0] readVal1;
    logic [31:0] readVal2;

    always_comb begin
        // x0 stays zero, out-of-range addresses are dropped
        writeHit = regWrite && (writeReg != 5'd0) && (int'(writeReg) < numRegs);

        readVal1 = (int'(readReg1) < numRegs) ? regs[readReg1[idxW-1:0]] : 32'd0;
        readVal2 = (int'(readReg2) < numRegs) ? regs[readReg2[idxW-1:0]] : 32'd0;
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= 32'd0;
            end
            readData1 <= 32'd0;
            readData2 <= 32'd0;
        end else begin
            // same-cycle write goes straight to the read port
            if (writeHit && writeReg == readReg1) begin
                readData1 <= writeData;
            end else begin
                readData1 <= readVal1;
            end

            if (writeHit && writeReg == readReg2) begin
                readData2 <= writeData;
            end else begin
                readData2 <= readVal2;
            end

            if (writeHit) begin
                regs[writeReg[idxW-1:0]] <= writeData;
            end
        end
    end

endmodule

//--- src/rvExecPkg.sv
package rvExecPkg;

    // alu operations, passB feeds lui straight through
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOp_e;

    // one operation on its way from decode to execute
    typedef struct packed {
        logic        valid;
        aluOp_e      aluOp;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        useImm;   // operand b from imm
        logic        zeroA;    // operand a forced to zero
        logic [31:0] imm;      // sign-extended or upper
        logic        writeEn;
        logic        illegal;
    } decodedOp_t;

    // finished instruction, also the write port of the register file
    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        logic        writeEn;
        logic        illegal;
    } execResult_t;

    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLui   = 7'b0110111;

endpackage

//--- test/execCoreTb.sv
module execCoreTb
    import rvExecPkg::*;
();

    logic        CLK;
    logic        RESET;
    logic [31:0] instr;
    logic        instrValid;
    execResult_t result;
    logic        resultValid;

    logic [31:0] model [32];   // reference register contents
    execResult_t expQ [$];
    string       testName;
    integer      seed = 32'hed15aee5;
    int          resultErrors = 0;   // counted by the monitor
    int          otherErrors = 0;
    int          received = 0;
    int          totalIssued = 0;
    int          cycles = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          issuedAtStart;
    int          receivedAtStart;
    int          errorsAtStart;

    execCore #(
        .numRegs (32)
    ) i_dut (
        .CLK         (CLK),
        .RESET       (RESET),
        .instr       (instr),
        .instrValid  (instrValid),
        .result      (result),
        .resultValid (resultValid)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (cycles > 4 * totalIssued + 100) begin
            $display("timeout after %0d cycles, %0d results still outstanding",
                     cycles, expQ.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge CLK) begin
        if (RESET && resultValid) begin
            received++;
            if (expQ.size() == 0) begin
                $display("%s: DUT reported a result for x%0d with nothing outstanding",
                         testName, result.rd);
                resultErrors++;
            end else begin
                checkResult(testName, expQ.pop_front(), result);
            end
        end
    end

    task automatic checkResult(input string name, input execResult_t want,
                               input execResult_t got);
        if (got !== want) begin
            $write("[FAIL] %s: expected rd=x%0d value=%h we=%b illegal=%b, ",
                   name, want.rd, want.value, want.writeEn, want.illegal);
            $display("actual rd=x%0d value=%h we=%b illegal=%b",
                     got.rd, got.value, got.writeEn, got.illegal);
            resultErrors++;
        end
    endtask

    task automatic checkCount(input string name, input int want, input int got);
        if (got != want) begin
            $display("[FAIL] %s: expected %0d results, actual %0d", name, want, got);
            otherErrors++;
        end
    endtask

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opOpImm};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, opLui};
    endfunction

    // rv32i semantics against the model registers
    function automatic execResult_t expectedOf(input logic [31:0] ins);
        execResult_t want;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        isOp;
        want = '0;
        want.rd = ins[11:7];
        isOp = (ins[6:0] == opOp);
        a = model[ins[19:15]];
        b = isOp ? model[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sh = b[4:0];
        if (ins[6:0] == opLui) begin
            want.value = {ins[31:12], 12'd0};
            want.writeEn = 1'b1;
        end else if (isOp || ins[6:0] == opOpImm) begin
            want.writeEn = 1'b1;
            case (ins[14:12])
                3'd0: want.value = (isOp && ins[30]) ? a - b : a + b;
                3'd1: want.value = a << sh;
                3'd2: want.value = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
                3'd3: want.value = {31'd0, a < b};
                3'd4: want.value = a ^ b;
                3'd5: want.value = (a >> sh) |
                                   ((ins[30] && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
                3'd6: want.value = a | b;
                default: want.value = a & b;
            endcase
        end else begin
            want.illegal = 1'b1;   // unknown opcode
        end
        return want;
    endfunction

    task automatic issue(input logic [31:0] ins);
        execResult_t want;
        @(negedge CLK);
        want = expectedOf(ins);
        if (want.writeEn && want.rd != 5'd0) model[want.rd] = want.value;
        expQ.push_back(want);
        instr = ins;
        instrValid = 1'b1;
        totalIssued++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge CLK);
            instrValid = 1'b0;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        issuedAtStart = totalIssued;
        receivedAtStart = received;
        errorsAtStart = resultErrors + otherErrors;
    endtask

    task automatic finishTest();
        idle(1);
        for (int i = 0; i < 6 && expQ.size() != 0; i++) begin
            idle(1);
        end
        idle(2);   // stray trailing results still get counted
        if (expQ.size() != 0) begin
            $display("%s: %0d results never came out of the DUT", testName, expQ.size());
            otherErrors++;
            expQ.delete();
        end
        checkCount(testName, totalIssued - issuedAtStart, received - receivedAtStart);
        if (resultErrors + otherErrors == errorsAtStart) begin
            $display("%s: passed", testName);
            testsPassed++;
        end else begin
            $display("%s: failed with %0d errors", testName,
                     resultErrors + otherErrors - errorsAtStart);
            testsFailed++;
        end
    endtask

    task automatic resetZero();
        startTest("resetZero");
        issue(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd5));   // add x5, x1, x2
        idle(2);
        issue(rType(7'h00, 5'd5, 5'd5, 3'd0, 5'd7));   // reads x5 back
        finishTest();
    endtask

    task automatic immAndLui();
        startTest("immAndLui");
        issue(iType(12'd100, 5'd0, 3'd0, 5'd1));
        issue(iType(12'hffb, 5'd0, 3'd0, 5'd2));       // x2 = -5
        issue(iType(12'hffc, 5'd2, 3'd2, 5'd3));       // slti -5 < -4
        issue(iType(12'd5, 5'd2, 3'd3, 5'd4));         // sltiu, -5 is huge unsigned
        issue(iType(12'hfff, 5'd1, 3'd3, 5'd4));
        issue(iType(12'hfff, 5'd1, 3'd4, 5'd5));       // xori -1
        issue(iType(12'h0f0, 5'd1, 3'd6, 5'd6));
        issue(iType(12'h07f, 5'd2, 3'd7, 5'd7));
        issue(iType(12'h004, 5'd2, 3'd1, 5'd8));       // slli 4
        issue(iType(12'h01c, 5'd2, 3'd5, 5'd9));       // srli 28
        issue(iType(12'h402, 5'd2, 3'd5, 5'd10));      // srai 2
        issue(uType(20'habcde, 5'd11));
        issue(iType(12'h923, 5'd11, 3'd0, 5'd11));     // negative imm onto upper bits
        finishTest();
    endtask

    task automatic regOps();
        startTest("regOps");
        issue(uType(20'h80000, 5'd1));
        issue(iType(12'h765, 5'd1, 3'd0, 5'd1));       // x1 = 0x80000765
        issue(iType(12'd37, 5'd0, 3'd0, 5'd2));        // shifts by 37 act as 5
        issue(iType(12'h123, 5'd0, 3'd0, 5'd3));
        for (int f = 0; f < 8; f++) begin
            issue(rType(7'h00, 5'd2, 5'd1, 3'(f), 5'(16 + f)));
        end
        issue(rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd24));  // sub
        issue(rType(7'h20, 5'd2, 5'd1, 3'd5, 5'd25));  // sra of a negative value
        issue(rType(7'h00, 5'd1, 5'd3, 3'd2, 5'd26));
        issue(rType(7'h00, 5'd1, 5'd3, 3'd3, 5'd27));
        finishTest();
    endtask

    task automatic dependChain();
        startTest("dependChain");
        issue(iType(12'd5, 5'd0, 3'd0, 5'd3));
        issue(rType(7'h00, 5'd3, 5'd3, 3'd0, 5'd3));   // x3 = x3 + x3, distance 1
        issue(iType(12'd1, 5'd0, 3'd0, 5'd4));
        issue(rType(7'h00, 5'd4, 5'd3, 3'd0, 5'd5));   // x3 from bypass, x4 forwarded
        idle(1);
        issue(rType(7'h20, 5'd3, 5'd5, 3'd0, 5'd6));
        idle(2);
        issue(rType(7'h00, 5'd5, 5'd6, 3'd4, 5'd7));
        issue(iType(12'd3, 5'd7, 3'd0, 5'd8));
        issue(rType(7'h00, 5'd4, 5'd8, 3'd1, 5'd8));
        finishTest();
    endtask

    task automatic zeroAndIllegal();
        startTest("zeroAndIllegal");
        issue(iType(12'd55, 5'd0, 3'd0, 5'd0));        // value reported, x0 unchanged
        issue(rType(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));   // must not see the 55
        issue(rType(7'h00, 5'd0, 5'd0, 3'd0, 5'd10));
        issue(iType(12'd9, 5'd0, 3'd0, 5'd12));
        issue({12'd0, 5'd0, 3'd2, 5'd12, 7'b0000011}); // load opcode is unknown here
        issue(rType(7'h00, 5'd0, 5'd12, 3'd0, 5'd13)); // x12 still 9
        finishTest();
    endtask

    task automatic randomMix();
        logic [31:0] rnd;
        logic [31:0] immRnd;
        logic [11:0] imm;
        logic [2:0]  f3;
        startTest("randomMix");
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            immRnd = $random(seed);
            f3 = rnd[13:11];
            imm = immRnd[11:0];
            if (rnd[1:0] == 2'd3) begin
                issue(uType(immRnd[31:12], {2'b0, rnd[4:2]}));
            end else if (rnd[1:0] == 2'd2) begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm[11:5] = (rnd[14] && f3 == 3'd5) ? 7'h20 : 7'h00;
                end
                issue(iType(imm, {2'b0, rnd[7:5]}, f3, {2'b0, rnd[4:2]}));
            end else begin
                issue(rType((rnd[14] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                            {2'b0, rnd[10:8]}, {2'b0, rnd[7:5]}, f3, {2'b0, rnd[4:2]}));
            end
            if (rnd[31:30] == 2'b00) idle({30'd0, rnd[29:28]});   // occasional bubbles
        end
        finishTest();
    endtask

    initial begin
        RESET = 1'b0;
        instr = 32'd0;
        instrValid = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model[r] = 32'd0;
        end
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b1;
        resetZero();
        immAndLui();
        regOps();
        dependChain();
        zeroAndIllegal();
        randomMix();
        $display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && resultErrors + otherErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/rvExecPkg.sv
src/regFile.sv
src/instrDecoder.sv
src/intAlu.sv
src/aluStage.sv
src/execCore.sv
test/execCoreTb.sv
